// File: all.f
z80Pkg.sv
instrDecoder.sv
instrAssembler.sv
z80Frontend.sv
tbChecker.sv
tbZ80Frontend.sv

// File: instrAssembler.sv
`default_nettype none

module instrAssembler (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  byteValid,
    input  z80Pkg::byte_t         byteIn,
    output z80Pkg::instrWord_t    window,
    output z80Pkg::opLen_t        opLen,
    input  z80Pkg::instrLen_t     len,
    input  z80Pkg::insnGroup_t    group,
    output logic                  instrValid,
    output z80Pkg::decodedInstr_t instr
);

    // bytes held from earlier strobes of the current instruction
    z80Pkg::opLen_t count;
    z80Pkg::instrWord_t held;
    logic complete;

    // incoming byte lands just above the held ones
    always_comb begin
        window = held;
        window[8 * count +: 8] = byteIn;
    end

    assign opLen = count;

    assign complete = byteValid
                   && (group != z80Pkg::GROUP_NEED_MORE_BYTES)
                   && (len == ({1'b0, count} + 3'd1));

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            held <= '0;
            instrValid <= 1'b0;
        end else begin
            instrValid <= complete;
            if (complete) begin
                // zero the window so unused upper bytes stay clean
                count <= '0;
                held <= '0;
            end else if (byteValid) begin
                count <= count + 2'd1;
                held <= window;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (complete) begin
            instr <= '{bytes: window, len: len, group: group};
        end
    end

endmodule

`default_nettype wire

// File: instrDecoder.sv
`default_nettype none

module instrDecoder (
    input  z80Pkg::instrWord_t window,
    input  z80Pkg::opLen_t     opLen,
    output z80Pkg::instrLen_t  len,
    output z80Pkg::insnGroup_t group
);

    z80Pkg::byte_t op0;
    z80Pkg::byte_t op1;
    z80Pkg::byte_t op3;
    logic isPrefix;
    z80Pkg::insnGroup_t bitGroup;

    assign op0 = window[7:0];
    assign op1 = window[15:8];
    assign op3 = window[31:24];
    assign isPrefix = (op0 == 8'hCB) || (op0 == 8'hDD) || (op0 == 8'hED) || (op0 == 8'hFD);

    // fourth byte of DD CB d op, only (ix+d) operands are defined
    always_comb begin
        bitGroup = z80Pkg::GROUP_ILLEGAL_INSTR;
        if (op3[2:0] == 3'd6) begin
            case (op3[7:6])
                2'd0: begin
                    if (op3[5:3] == 3'd6)
                        bitGroup = z80Pkg::GROUP_ILLEGAL_INSTR;
                    else if (op3[5])
                        bitGroup = z80Pkg::GROUP_SHIFT_IDX_IXIY;
                    else
                        bitGroup = z80Pkg::GROUP_RR_RLC_IDX_IXIY;
                end
                2'd1: bitGroup = z80Pkg::GROUP_BIT_IDX_IXIY;
                2'd2: bitGroup = z80Pkg::GROUP_RES_IDX_IXIY;
                default: bitGroup = z80Pkg::GROUP_SET_IDX_IXIY;
            endcase
        end
    end

    always_comb begin
        group = z80Pkg::GROUP_ILLEGAL_INSTR;
        len = 3'd1;
        if (!isPrefix) begin
            // the unprefixed opcode decides the length alone, whatever the count
            casez (op0)
                8'h00: group = z80Pkg::GROUP_NOP;
                8'h08: group = z80Pkg::GROUP_EX_AF_AF2;
                8'b00??0001: begin
                    group = z80Pkg::GROUP_LD_DD_NN;
                    len = 3'd3;
                end
                8'b00??1001: group = z80Pkg::GROUP_ADD_HL_DD;
                8'b000?0010: group = z80Pkg::GROUP_LD_IND_BCDE_A;
                8'b000?1010: group = z80Pkg::GROUP_LD_A_IND_BCDE;
                8'b001??010: begin
                    len = 3'd3;
                    case (op0[4:3])
                        2'd0: group = z80Pkg::GROUP_LD_IND_NN_HL;
                        2'd1: group = z80Pkg::GROUP_LD_HL_IND_NN;
                        2'd2: group = z80Pkg::GROUP_LD_IND_NN_A;
                        default: group = z80Pkg::GROUP_LD_A_IND_NN;
                    endcase
                end
                8'b00???011: group = z80Pkg::GROUP_INC_DEC_DD;
                8'h34, 8'h35: group = z80Pkg::GROUP_INC_DEC_IND_HL;
                8'b00???10?: group = z80Pkg::GROUP_INC_DEC_REG;
                8'b00???110: begin
                    group = (op0 == 8'h36) ? z80Pkg::GROUP_LD_IND_HL_N
                                           : z80Pkg::GROUP_LD_REG_N;
                    len = 3'd2;
                end
                8'b000??111: group = z80Pkg::GROUP_RR_RLCA;
                8'h27: group = z80Pkg::GROUP_DAA;
                8'h2F: group = z80Pkg::GROUP_CPL;
                8'h37: group = z80Pkg::GROUP_SCF;
                8'h3F: group = z80Pkg::GROUP_CCF;
                8'h76: group = z80Pkg::GROUP_HALT;
                8'b01110???: group = z80Pkg::GROUP_LD_IND_HL_REG;
                // ld r,(hl) is not decoded here
                8'b01???110: group = z80Pkg::GROUP_ILLEGAL_INSTR;
                8'b01??????: group = z80Pkg::GROUP_LD_REG_REG;
                8'b10???110: group = z80Pkg::GROUP_ALU_A_IND_HL;
                8'b10??????: group = z80Pkg::GROUP_ALU_A_REG;
                8'hC3, 8'b11???010: begin
                    group = (op0 == 8'hC3) ? z80Pkg::GROUP_JP : z80Pkg::GROUP_JP_COND;
                    len = 3'd3;
                end
                8'b11??0001: group = z80Pkg::GROUP_POP_QQ;
                8'b11??0101: group = z80Pkg::GROUP_PUSH_QQ;
                8'hD9: group = z80Pkg::GROUP_EXX;
                8'hF9: group = z80Pkg::GROUP_LD_SP_HL;
                8'hE3: group = z80Pkg::GROUP_EX_IND_SP_HL;
                8'hEB: group = z80Pkg::GROUP_EX_DE_HL;
                8'hF3, 8'hFB: group = z80Pkg::GROUP_EI_DI;
                8'b11???110: begin
                    group = z80Pkg::GROUP_ALU_A_N;
                    len = 3'd2;
                end
                default: group = z80Pkg::GROUP_ILLEGAL_INSTR;
            endcase
        end else if (opLen == 2'd0) begin
            group = z80Pkg::GROUP_NEED_MORE_BYTES;
            len = 3'd2;
        end else if (op0 == 8'hCB) begin
            len = 3'd2;
            casez (op1)
                8'b00110???: group = z80Pkg::GROUP_ILLEGAL_INSTR;
                8'b000??110: group = z80Pkg::GROUP_RR_RLC_IND_HL;
                8'b000?????: group = z80Pkg::GROUP_RR_RLC_REG;
                8'b00???110: group = z80Pkg::GROUP_SHIFT_IND_HL;
                8'b00??????: group = z80Pkg::GROUP_SHIFT_REG;
                8'b01???110: group = z80Pkg::GROUP_BIT_IND_HL;
                8'b01??????: group = z80Pkg::GROUP_BIT_REG;
                8'b10???110: group = z80Pkg::GROUP_RES_IND_HL;
                8'b10??????: group = z80Pkg::GROUP_RES_REG;
                8'b11???110: group = z80Pkg::GROUP_SET_IND_HL;
                default: group = z80Pkg::GROUP_SET_REG;
            endcase
        end else if (op0 == 8'hED) begin
            len = 3'd2;
            casez (op1)
                8'b01???010: group = z80Pkg::GROUP_ADC_SBC_HL_DD;
                8'b01???011: begin
                    group = op1[3] ? z80Pkg::GROUP_LD_DD_IND_NN : z80Pkg::GROUP_LD_IND_NN_DD;
                    len = 3'd4;
                end
                8'h44: group = z80Pkg::GROUP_NEG;
                8'h47: group = z80Pkg::GROUP_LD_I_A;
                8'h4F: group = z80Pkg::GROUP_LD_R_A;
                8'h57: group = z80Pkg::GROUP_LD_A_I;
                8'h5F: group = z80Pkg::GROUP_LD_A_R;
                8'h67, 8'h6F: group = z80Pkg::GROUP_ROT_DEC;
                8'hA0: group = z80Pkg::GROUP_LDI;
                8'hA1: group = z80Pkg::GROUP_CPI;
                8'hA8: group = z80Pkg::GROUP_LDD;
                8'hA9: group = z80Pkg::GROUP_CPD;
                8'hB0: group = z80Pkg::GROUP_LDIR;
                8'hB1: group = z80Pkg::GROUP_CPIR;
                8'hB8: group = z80Pkg::GROUP_LDDR;
                8'hB9: group = z80Pkg::GROUP_CPDR;
                default: group = z80Pkg::GROUP_ILLEGAL_INSTR;
            endcase
        end else begin
            // DD and FD share one table
            len = 3'd2;
            casez (op1)
                8'b00??1001: group = z80Pkg::GROUP_ADD_IXIY_SS;
                8'h23, 8'h2B: group = z80Pkg::GROUP_INC_DEC_IXIY;
                8'h21, 8'h22, 8'h2A, 8'h36: begin
                    len = 3'd4;
                    case (op1)
                        8'h21: group = z80Pkg::GROUP_LD_IXIY_NN;
                        8'h22: group = z80Pkg::GROUP_LD_IND_NN_IXIY;
                        8'h2A: group = z80Pkg::GROUP_LD_IXIY_IND_NN;
                        default: group = z80Pkg::GROUP_LD_IDX_IXIY_N;
                    endcase
                end
                8'h76: group = z80Pkg::GROUP_ILLEGAL_INSTR;
                8'h34, 8'h35, 8'b01110???, 8'b01???110, 8'b10???110: begin
                    len = 3'd3;
                    if (op1[7:1] == 7'h1A)
                        group = z80Pkg::GROUP_INC_DEC_IDX_IXIY;
                    else if (op1[7:3] == 5'b01110)
                        group = z80Pkg::GROUP_LD_IDX_IXIY_REG;
                    else if (op1[7])
                        group = z80Pkg::GROUP_ALU_A_IDX_IXIY;
                    else
                        group = z80Pkg::GROUP_LD_REG_IDX_IXIY;
                end
                8'hE1: group = z80Pkg::GROUP_POP_IXIY;
                8'hE3: group = z80Pkg::GROUP_EX_IND_SP_IXIY;
                8'hE5: group = z80Pkg::GROUP_PUSH_IXIY;
                8'hF9: group = z80Pkg::GROUP_LD_SP_IXIY;
                8'hCB: begin
                    // offset comes third, the real opcode fourth
                    len = 3'd4;
                    group = (opLen == 2'd3) ? bitGroup : z80Pkg::GROUP_IDX_IXIY_BITS;
                end
                default: group = z80Pkg::GROUP_ILLEGAL_INSTR;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tbZ80Frontend -f all.f -o simZ80 \
    && ./obj_dir/simZ80 | tee /dev/stderr | grep -qF "Done: no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tbChecker.sv
`default_nettype none

module tbChecker (
    input logic                  clk,
    input logic                  instrValid,
    input z80Pkg::decodedInstr_t instr
);

    z80Pkg::decodedInstr_t expected [$];
    int seenCount = 0;
    int passCount = 0;
    int errorCount = 0;
    int negCount = 0;
    int dueAt [$];

    task pushExpected(input z80Pkg::decodedInstr_t entry);
        expected.push_back(entry);
    endtask

    // the last byte is driven now and its pulse shows two falling edges later
    task expectPulse();
        dueAt.push_back(negCount + 2);
    endtask

    function automatic int fieldMismatch(input string name, input logic [31:0] got,
                                         input logic [31:0] want);
        if (got !== want) begin
            $display("Error at %0t: %s = %h, expected %h", $time, name, got, want);
            return 1;
        end
        return 0;
    endfunction

    // outputs change on the rising edge, so look at them on the falling one
    always @(negedge clk) begin : watch
        z80Pkg::decodedInstr_t want;
        int errs;
        int due;
        negCount = negCount + 1;
        if (instrValid) begin
            seenCount = seenCount + 1;
            if (expected.size() == 0) begin
                $display("test %0d: DUT emitted instruction %h while none was expected",
                         seenCount, instr.bytes);
                errorCount = errorCount + 1;
            end else begin
                want = expected.pop_front();
                due = -1;
                if (dueAt.size() != 0)
                    due = dueAt.pop_front();
                errs = fieldMismatch("instr.bytes", instr.bytes, want.bytes);
                errs += fieldMismatch("instr.len", 32'(instr.len), 32'(want.len));
                errs += fieldMismatch("instr.group", 32'(instr.group), 32'(want.group));
                if (negCount != due) begin
                    $display("Error at %0t: instrValid cycle = %0d, expected %0d",
                             $time, negCount, due);
                    errs += 1;
                end
                errorCount = errorCount + errs;
                if (errs == 0) begin
                    passCount = passCount + 1;
                    $display("test %0d: bytes %h len %0d group %0d ok",
                             seenCount, instr.bytes, instr.len, instr.group);
                end else begin
                    $display("test %0d: bytes %h failed", seenCount, want.bytes);
                end
            end
        end
    end

    // leftovers count as errors
    task closeOut(output int total);
        total = errorCount + expected.size();
        if (expected.size() != 0) begin
            $display("%0d expected instructions never came out of the DUT", expected.size());
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 seenCount, passCount, seenCount - passCount, total);
    endtask

endmodule

`default_nettype wire

// File: tbZ80Frontend.sv
`default_nettype none

module tbZ80Frontend;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic byteValid = 1'b0;
    z80Pkg::byte_t byteIn = 8'h00;
    logic instrValid;
    z80Pkg::decodedInstr_t instr;

    int seed = 74815;
    int cycleCount = 0;
    int cycleLimit = 0;
    int numEntries = 0;
    int numInstr = 0;
    logic [31:0] tblBytes [32];
    logic [3:0] tblFixed [32];
    int tblLen [32];
    z80Pkg::insnGroup_t tblGroup [32];
    z80Pkg::byte_t stream [$];
    int gaps [$];
    bit lastByte [$];

    z80Frontend i_dut (
        .clk        (clk),
        .reset      (reset),
        .byteValid  (byteValid),
        .byteIn     (byteIn),
        .instrValid (instrValid),
        .instr      (instr)
    );

    tbChecker i_checker (
        .clk        (clk),
        .instrValid (instrValid),
        .instr      (instr)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Done: errors found");
            $finish;
        end
    end

    // fixed marks the bytes taken from the table, the others are random operands
    task addEntry(input logic [31:0] bytes, input logic [3:0] fixed, input int len,
                  input z80Pkg::insnGroup_t group);
        tblBytes[numEntries] = bytes;
        tblFixed[numEntries] = fixed;
        tblLen[numEntries] = len;
        tblGroup[numEntries] = group;
        numEntries = numEntries + 1;
    endtask

    task queueInstr(input int k, input int spacing);
        int b;
        logic [31:0] rnd;
        logic [31:0] word;
        z80Pkg::decodedInstr_t entry;
        rnd = $random(seed);
        word = tblBytes[k];
        for (b = 0; b < tblLen[k]; b++) begin
            if (!tblFixed[k][b])
                word[8 * b +: 8] = rnd[8 * b +: 8];
            stream.push_back(word[8 * b +: 8]);
            gaps.push_back(spacing ? ($unsigned($random(seed)) % 3) : 0);
            lastByte.push_back(b == tblLen[k] - 1);
        end
        entry.bytes = word;
        entry.len = z80Pkg::instrLen_t'(tblLen[k]);
        entry.group = tblGroup[k];
        i_checker.pushExpected(entry);
        numInstr = numInstr + 1;
    endtask

    initial begin : stimulus
        int i;
        int errs;
        addEntry(32'h00, 4'b0001, 1, z80Pkg::GROUP_NOP);
        addEntry(32'h01, 4'b0001, 3, z80Pkg::GROUP_LD_DD_NN);
        addEntry(32'h3E, 4'b0001, 2, z80Pkg::GROUP_LD_REG_N);
        addEntry(32'h41, 4'b0001, 1, z80Pkg::GROUP_LD_REG_REG);
        addEntry(32'h76, 4'b0001, 1, z80Pkg::GROUP_HALT);
        addEntry(32'hC6, 4'b0001, 2, z80Pkg::GROUP_ALU_A_N);
        addEntry(32'hC3, 4'b0001, 3, z80Pkg::GROUP_JP);
        addEntry(32'hE5, 4'b0001, 1, z80Pkg::GROUP_PUSH_QQ);
        addEntry(32'h10, 4'b0001, 1, z80Pkg::GROUP_ILLEGAL_INSTR);
        addEntry(32'h06CB, 4'b0011, 2, z80Pkg::GROUP_RR_RLC_IND_HL);
        addEntry(32'h47CB, 4'b0011, 2, z80Pkg::GROUP_BIT_REG);
        addEntry(32'h30CB, 4'b0011, 2, z80Pkg::GROUP_ILLEGAL_INSTR);
        addEntry(32'h44ED, 4'b0011, 2, z80Pkg::GROUP_NEG);
        addEntry(32'h4BED, 4'b0011, 4, z80Pkg::GROUP_LD_DD_IND_NN);
        addEntry(32'h00ED, 4'b0011, 2, z80Pkg::GROUP_ILLEGAL_INSTR);
        addEntry(32'h21DD, 4'b0011, 4, z80Pkg::GROUP_LD_IXIY_NN);
        addEntry(32'h7EFD, 4'b0011, 3, z80Pkg::GROUP_LD_REG_IDX_IXIY);
        addEntry(32'h76DD, 4'b0011, 2, z80Pkg::GROUP_ILLEGAL_INSTR);
        // DD CB d op with a random offset and a fixed opcode
        addEntry(32'h0600CBDD, 4'b1011, 4, z80Pkg::GROUP_RR_RLC_IDX_IXIY);
        addEntry(32'h4600CBFD, 4'b1011, 4, z80Pkg::GROUP_BIT_IDX_IXIY);
        addEntry(32'h8600CBDD, 4'b1011, 4, z80Pkg::GROUP_RES_IDX_IXIY);
        addEntry(32'hC600CBFD, 4'b1011, 4, z80Pkg::GROUP_SET_IDX_IXIY);
        // every table entry once, then random picks
        for (i = 0; i < numEntries; i++) begin
            queueInstr(i, 1);
        end
        repeat (24) queueInstr($unsigned($random(seed)) % numEntries, 1);
        // back-to-back part of the stream
        repeat (24) queueInstr($unsigned($random(seed)) % numEntries, 0);
        cycleLimit = stream.size() * 3 + 50;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        for (i = 0; i < stream.size(); i++) begin
            repeat (gaps[i]) begin
                @(posedge clk);
                byteValid <= 1'b0;
            end
            @(posedge clk);
            byteValid <= 1'b1;
            byteIn <= stream[i];
            if (lastByte[i])
                i_checker.expectPulse();
        end
        @(posedge clk);
        byteValid <= 1'b0;
        while (i_checker.seenCount < numInstr) begin
            @(posedge clk);
        end
        // a few more cycles to catch stray pulses
        repeat (4) @(posedge clk);
        i_checker.closeOut(errs);
        if (errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: z80Frontend.sv
`default_nettype none

module z80Frontend (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  byteValid,
    input  z80Pkg::byte_t         byteIn,
    output logic                  instrValid,
    output z80Pkg::decodedInstr_t instr
);

    z80Pkg::instrWord_t window;
    z80Pkg::opLen_t opLen;
    z80Pkg::instrLen_t len;
    z80Pkg::insnGroup_t group;

    instrAssembler i_assembler (
        .clk        (clk),
        .reset      (reset),
        .byteValid  (byteValid),
        .byteIn     (byteIn),
        .window     (window),
        .opLen      (opLen),
        .len        (len),
        .group      (group),
        .instrValid (instrValid),
        .instr      (instr)
    );

    instrDecoder i_decoder (
        .window (window),
        .opLen  (opLen),
        .len    (len),
        .group  (group)
    );

endmodule

`default_nettype wire

// File: z80Pkg.sv
`default_nettype none

package z80Pkg;

    typedef logic [7:0] byte_t;
    // little-endian, first byte in [7:0]
    typedef logic [31:0] instrWord_t;
    typedef logic [2:0] instrLen_t;
    typedef logic [1:0] opLen_t;
    typedef logic [7:0] insnGroup_t;

    localparam insnGroup_t GROUP_NEED_MORE_BYTES = 8'd0;
    localparam insnGroup_t GROUP_ILLEGAL_INSTR = 8'd1;

    // unprefixed
    localparam insnGroup_t GROUP_NOP = 8'd2;
    localparam insnGroup_t GROUP_LD_DD_NN = 8'd3;
    localparam insnGroup_t GROUP_LD_IND_BCDE_A = 8'd4;
    localparam insnGroup_t GROUP_INC_DEC_DD = 8'd5;
    localparam insnGroup_t GROUP_INC_DEC_REG = 8'd6;
    localparam insnGroup_t GROUP_RR_RLCA = 8'd7;
    localparam insnGroup_t GROUP_ADD_HL_DD = 8'd8;
    localparam insnGroup_t GROUP_DAA = 8'd9;
    localparam insnGroup_t GROUP_CPL = 8'd10;
    localparam insnGroup_t GROUP_INC_DEC_IND_HL = 8'd11;
    localparam insnGroup_t GROUP_LD_A_IND_BCDE = 8'd12;
    localparam insnGroup_t GROUP_LD_REG_N = 8'd13;
    localparam insnGroup_t GROUP_LD_IND_NN_HL = 8'd14;
    localparam insnGroup_t GROUP_LD_HL_IND_NN = 8'd15;
    localparam insnGroup_t GROUP_LD_IND_HL_N = 8'd16;
    localparam insnGroup_t GROUP_LD_REG_REG = 8'd17;
    localparam insnGroup_t GROUP_LD_IND_NN_A = 8'd18;
    localparam insnGroup_t GROUP_SCF = 8'd19;
    localparam insnGroup_t GROUP_LD_A_IND_NN = 8'd20;
    localparam insnGroup_t GROUP_CCF = 8'd21;
    localparam insnGroup_t GROUP_LD_IND_HL_REG = 8'd22;
    localparam insnGroup_t GROUP_HALT = 8'd23;
    localparam insnGroup_t GROUP_JP = 8'd24;
    localparam insnGroup_t GROUP_JP_COND = 8'd25;
    localparam insnGroup_t GROUP_POP_QQ = 8'd26;
    localparam insnGroup_t GROUP_PUSH_QQ = 8'd27;
    localparam insnGroup_t GROUP_EX_AF_AF2 = 8'd28;
    localparam insnGroup_t GROUP_EX_IND_SP_HL = 8'd29;
    localparam insnGroup_t GROUP_EX_DE_HL = 8'd30;
    localparam insnGroup_t GROUP_EXX = 8'd31;
    localparam insnGroup_t GROUP_LD_SP_HL = 8'd32;
    localparam insnGroup_t GROUP_ALU_A_REG = 8'd33;
    localparam insnGroup_t GROUP_ALU_A_IND_HL = 8'd34;
    localparam insnGroup_t GROUP_ALU_A_N = 8'd35;
    localparam insnGroup_t GROUP_EI_DI = 8'd36;

    // CB prefix
    localparam insnGroup_t GROUP_RR_RLC_REG = 8'd40;
    localparam insnGroup_t GROUP_RR_RLC_IND_HL = 8'd41;
    localparam insnGroup_t GROUP_SHIFT_REG = 8'd42;
    localparam insnGroup_t GROUP_SHIFT_IND_HL = 8'd43;
    localparam insnGroup_t GROUP_BIT_REG = 8'd44;
    localparam insnGroup_t GROUP_BIT_IND_HL = 8'd45;
    localparam insnGroup_t GROUP_SET_REG = 8'd46;
    localparam insnGroup_t GROUP_SET_IND_HL = 8'd47;
    localparam insnGroup_t GROUP_RES_REG = 8'd48;
    localparam insnGroup_t GROUP_RES_IND_HL = 8'd49;

    // ED prefix
    localparam insnGroup_t GROUP_ADC_SBC_HL_DD = 8'd56;
    localparam insnGroup_t GROUP_LD_DD_IND_NN = 8'd57;
    localparam insnGroup_t GROUP_NEG = 8'd58;
    localparam insnGroup_t GROUP_LD_IND_NN_DD = 8'd59;
    localparam insnGroup_t GROUP_LD_I_A = 8'd60;
    localparam insnGroup_t GROUP_LD_R_A = 8'd61;
    localparam insnGroup_t GROUP_LD_A_I = 8'd62;
    localparam insnGroup_t GROUP_LD_A_R = 8'd63;
    localparam insnGroup_t GROUP_ROT_DEC = 8'd64;
    localparam insnGroup_t GROUP_LDI = 8'd65;
    localparam insnGroup_t GROUP_CPI = 8'd66;
    localparam insnGroup_t GROUP_LDD = 8'd67;
    localparam insnGroup_t GROUP_CPD = 8'd68;
    localparam insnGroup_t GROUP_LDIR = 8'd69;
    localparam insnGroup_t GROUP_CPIR = 8'd70;
    localparam insnGroup_t GROUP_LDDR = 8'd71;
    localparam insnGroup_t GROUP_CPDR = 8'd72;

    // DD / FD prefix
    localparam insnGroup_t GROUP_ADD_IXIY_SS = 8'd80;
    localparam insnGroup_t GROUP_INC_DEC_IXIY = 8'd81;
    localparam insnGroup_t GROUP_LD_REG_IDX_IXIY = 8'd82;
    localparam insnGroup_t GROUP_LD_IDX_IXIY_REG = 8'd83;
    localparam insnGroup_t GROUP_LD_IXIY_NN = 8'd84;
    localparam insnGroup_t GROUP_LD_IXIY_IND_NN = 8'd85;
    localparam insnGroup_t GROUP_INC_DEC_IDX_IXIY = 8'd86;
    localparam insnGroup_t GROUP_LD_IDX_IXIY_N = 8'd87;
    localparam insnGroup_t GROUP_EX_IND_SP_IXIY = 8'd88;
    localparam insnGroup_t GROUP_POP_IXIY = 8'd89;
    localparam insnGroup_t GROUP_PUSH_IXIY = 8'd90;
    localparam insnGroup_t GROUP_LD_IND_NN_IXIY = 8'd91;
    localparam insnGroup_t GROUP_ALU_A_IDX_IXIY = 8'd92;
    localparam insnGroup_t GROUP_LD_SP_IXIY = 8'd93;
    localparam insnGroup_t GROUP_IDX_IXIY_BITS = 8'd94;

    // DD CB d op / FD CB d op, chosen by the fourth byte
    localparam insnGroup_t GROUP_RR_RLC_IDX_IXIY = 8'd100;
    localparam insnGroup_t GROUP_SHIFT_IDX_IXIY = 8'd101;
    localparam insnGroup_t GROUP_BIT_IDX_IXIY = 8'd102;
    localparam insnGroup_t GROUP_SET_IDX_IXIY = 8'd103;
    localparam insnGroup_t GROUP_RES_IDX_IXIY = 8'd104;

    typedef struct packed {
        instrWord_t bytes;
        instrLen_t len;
        insnGroup_t group;
    } decodedInstr_t;

endpackage

`default_nettype wire
